// ==== cpu_bus_defs.svh ====
// frame length, frame phase numbers, opcode values and testbench memory index width
`ifndef CPU_BUS_DEFS_SVH
`define CPU_BUS_DEFS_SVH

// one bus frame, phases 0 (idle) to 9
`define FRAME_LEN         10
`define PH_ADDR_FIRST     1   // address and write data, low byte first
`define PH_ADDR_LAST      4
`define PH_STATUS         5   // write flag and halted
`define PH_DATA_IN_FIRST  6   // read bytes on uio_in, phases 6 to 9

// opcode field, instruction bits 31..28
`define OP_NOP   4'd0
`define OP_LDI   4'd1
`define OP_LD    4'd2
`define OP_ST    4'd3
`define OP_ADD   4'd4
`define OP_SUB   4'd5
`define OP_JZ    4'd6
`define OP_JMP   4'd7
`define OP_HALT  4'd15

`define TB_MEM_AW  6  // 64 words of external memory

`endif

// ==== cpu_bus_pkg.sv ====
// word, byte, phase and opcode types and the processor state enum
package cpu_bus_pkg;

  // address, data or instruction
  typedef logic [31:0] word_t;

  // one pin group value
  typedef logic [7:0] byte_t;

  // frame phase, 0 to 9
  typedef logic [3:0] phase_t;

  // instruction bits 31..28
  typedef logic [3:0] opcode_t;

  // operand in bits 23..0, address or zero-extended immediate
  typedef logic [23:0] operand_t;

  // processor sequencing
  //   fetch       one cycle after reset, no request
  //   wait_fetch  instruction frame outstanding
  //   execute     decode, next request shown combinationally
  //   wait_data   load or store frame outstanding
  //   halted      no more frames until reset
  typedef enum logic [2:0] {
    fetch      = 3'd0,
    wait_fetch = 3'd1,
    execute    = 3'd2,
    wait_data  = 3'd3,
    halted     = 3'd4
  } cpu_state_e;

endpackage

// ==== bus_serializer.sv ====
// byte-serial bus frame engine: phase counter, byte muxing, read assembly, oe and done
`include "cpu_bus_defs.svh"

module bus_serializer (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic                bus_req,
  input  cpu_bus_pkg::word_t  bus_addr,
  input  cpu_bus_pkg::word_t  bus_wdata,
  input  logic                bus_write,
  input  logic                halted,
  input  cpu_bus_pkg::byte_t  pin_in,
  output logic                bus_done,
  output cpu_bus_pkg::word_t  bus_rdata,
  output cpu_bus_pkg::byte_t  pin_addr,
  output cpu_bus_pkg::byte_t  pin_data,
  output cpu_bus_pkg::byte_t  pin_oe
);

  localparam cpu_bus_pkg::phase_t last_phase   = cpu_bus_pkg::phase_t'(`FRAME_LEN - 1);
  localparam cpu_bus_pkg::phase_t addr_first   = cpu_bus_pkg::phase_t'(`PH_ADDR_FIRST);
  localparam cpu_bus_pkg::phase_t addr_last    = cpu_bus_pkg::phase_t'(`PH_ADDR_LAST);
  localparam cpu_bus_pkg::phase_t status_phase = cpu_bus_pkg::phase_t'(`PH_STATUS);
  localparam cpu_bus_pkg::phase_t rd_first     = cpu_bus_pkg::phase_t'(`PH_DATA_IN_FIRST);

  cpu_bus_pkg::phase_t phase;
  logic [1:0]          byte_idx;   // which byte of addr / wdata goes out
  logic                in_addr;    // phases 1..4
  logic [23:0]         rd_lo;      // read bytes 0..2, shifted in low first

  // picks byte idx of a word, 0 is bits 7..0
  function automatic cpu_bus_pkg::byte_t pick_byte(input cpu_bus_pkg::word_t w,
                                                   input logic [1:0] idx);
    pick_byte = w[{idx, 3'b000} +: 8];
  endfunction

  assign in_addr  = (phase >= addr_first) && (phase <= addr_last);
  assign byte_idx = phase[1:0] - 2'd1;  // phase 1..4 -> 0..3

  // frame phase counter
  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else if (phase == '0) begin
      if (bus_req && run) begin  // run only gates the start
        phase <= addr_first;
      end
    end else if (phase == last_phase) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  // registered pins, value for a phase shows in the following cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      pin_addr <= '0;
      pin_data <= '0;
      pin_oe   <= '0;
    end else if (in_addr) begin
      pin_addr <= pick_byte(bus_addr, byte_idx);
      if (bus_write) begin
        pin_data <= pick_byte(bus_wdata, byte_idx);
        pin_oe   <= 8'hff;
      end else begin
        pin_data <= '0;  // read frame keeps uio quiet
        pin_oe   <= '0;
      end
    end else if (phase == status_phase) begin
      pin_addr <= {6'b0, halted, bus_write};
      pin_data <= '0;
      pin_oe   <= '0;
    end else begin
      // idle and read phases
      pin_addr <= {6'b0, halted, 1'b0};
      pin_data <= '0;
      pin_oe   <= '0;
    end
  end

  // read bytes 0..2 shift down from the top, byte 3 arrives in the last phase
  always_ff @(posedge clk) begin
    if ((phase >= rd_first) && (phase < last_phase)) begin
      rd_lo <= {pin_in, rd_lo[23:8]};
    end
  end

  assign bus_rdata = {pin_in, rd_lo};  // valid with bus_done
  assign bus_done  = (phase == last_phase);

endmodule

// ==== accum_cpu.sv ====
// accumulator processor: pc, instruction register, acc, state machine and bus requests
`include "cpu_bus_defs.svh"

module accum_cpu (
  input  logic                clk,
  input  logic                reset,
  input  logic                bus_done,
  input  cpu_bus_pkg::word_t  bus_rdata,
  output logic                bus_req,
  output cpu_bus_pkg::word_t  bus_addr,
  output cpu_bus_pkg::word_t  bus_wdata,
  output logic                bus_write,
  output logic                halted
);

  cpu_bus_pkg::cpu_state_e state;
  cpu_bus_pkg::word_t      pc;      // word address of current instruction
  cpu_bus_pkg::word_t      acc;
  cpu_bus_pkg::word_t      ir;

  cpu_bus_pkg::opcode_t    op;
  cpu_bus_pkg::operand_t   operand;
  cpu_bus_pkg::word_t      operand_w;   // zero extended
  cpu_bus_pkg::word_t      next_pc;
  logic                    needs_data;  // second frame needed
  logic                    is_store;
  logic                    is_halt;

  // instruction fields
  assign op        = cpu_bus_pkg::opcode_t'(ir[31:28]);
  assign operand   = ir[23:0];
  assign operand_w = {8'b0, operand};

  always_comb begin
    needs_data = 1'b0;
    case (op)
      `OP_LD, `OP_ST, `OP_ADD, `OP_SUB: needs_data = 1'b1;
      default:                          needs_data = 1'b0;
    endcase
  end

  assign is_store = (op == `OP_ST);
  assign is_halt  = (op == `OP_HALT);

  // branch decision
  always_comb begin
    next_pc = pc + 32'd1;
    if (op == `OP_JMP) begin
      next_pc = operand_w;
    end else if ((op == `OP_JZ) && (acc == '0)) begin
      next_pc = operand_w;
    end
  end

  // bus request, steady from raise until done
  always_comb begin
    bus_req   = 1'b0;
    bus_addr  = pc;
    bus_write = 1'b0;
    bus_wdata = acc;   // only meaningful for ST
    case (state)
      cpu_bus_pkg::wait_fetch: begin
        bus_req = 1'b1;
      end
      cpu_bus_pkg::execute: begin
        // next frame starts straight from decode, so only one idle cycle
        if (needs_data) begin
          bus_req   = 1'b1;
          bus_addr  = operand_w;
          bus_write = is_store;
        end else if (!is_halt) begin
          bus_req  = 1'b1;
          bus_addr = next_pc;  // becomes pc on the next edge
        end
      end
      cpu_bus_pkg::wait_data: begin
        bus_req   = 1'b1;
        bus_addr  = operand_w;
        bus_write = is_store;
      end
      default: begin
        bus_req = 1'b0;  // fetch and halted
      end
    endcase
  end

  // sequencing
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cpu_bus_pkg::fetch;
      pc    <= '0;
      acc   <= '0;
    end else begin
      case (state)
        cpu_bus_pkg::fetch: begin
          state <= cpu_bus_pkg::wait_fetch;
        end
        cpu_bus_pkg::wait_fetch: begin
          if (bus_done) begin
            state <= cpu_bus_pkg::execute;
          end
        end
        cpu_bus_pkg::execute: begin
          if (is_halt) begin
            state <= cpu_bus_pkg::halted;
          end else if (needs_data) begin
            state <= cpu_bus_pkg::wait_data;
          end else begin
            if (op == `OP_LDI) begin
              acc <= operand_w;
            end
            pc    <= next_pc;  // NOP, LDI, JZ, JMP and unknown opcodes
            state <= cpu_bus_pkg::wait_fetch;
          end
        end
        cpu_bus_pkg::wait_data: begin
          if (bus_done) begin
            case (op)
              `OP_LD:  acc <= bus_rdata;
              `OP_ADD: acc <= acc + bus_rdata;  // wraps at 32 bits
              `OP_SUB: acc <= acc - bus_rdata;
              default: acc <= acc;              // store leaves acc alone
            endcase
            pc    <= pc + 32'd1;
            state <= cpu_bus_pkg::wait_fetch;
          end
        end
        default: begin
          state <= cpu_bus_pkg::halted;  // stays until reset
        end
      endcase
    end
  end

  // instruction register, loaded at the end of each fetch frame
  always_ff @(posedge clk) begin
    if ((state == cpu_bus_pkg::wait_fetch) && bus_done) begin
      ir <= bus_rdata;
    end
  end

  assign halted = (state == cpu_bus_pkg::halted);

endmodule

// ==== cpu_bus_top.sv ====
// top level: pin mapping, processor and bus serializer
module cpu_bus_top (
  input  logic                clk,
  input  logic                reset,
  input  cpu_bus_pkg::byte_t  ui_in,
  input  cpu_bus_pkg::byte_t  uio_in,
  output cpu_bus_pkg::byte_t  uo_out,
  output cpu_bus_pkg::byte_t  uio_out,
  output cpu_bus_pkg::byte_t  uio_oe
);

  logic               run;
  logic               bus_req;
  logic               bus_write;
  logic               bus_done;
  logic               halted;
  cpu_bus_pkg::word_t bus_addr;
  cpu_bus_pkg::word_t bus_wdata;
  cpu_bus_pkg::word_t bus_rdata;

  assign run = ui_in[0];  // other ui_in bits spare

  accum_cpu u_cpu (
    .clk       (clk),
    .reset     (reset),
    .bus_done  (bus_done),
    .bus_rdata (bus_rdata),
    .bus_req   (bus_req),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_write (bus_write),
    .halted    (halted)
  );

  bus_serializer u_bus (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .bus_req   (bus_req),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_write (bus_write),
    .halted    (halted),
    .pin_in    (uio_in),
    .bus_done  (bus_done),
    .bus_rdata (bus_rdata),
    .pin_addr  (uo_out),     // address bytes and status
    .pin_data  (uio_out),    // write data
    .pin_oe    (uio_oe)
  );

endmodule

// ==== tb_cpu_bus.sv ====
// testbench with clock, reset, external memory bus model, test table, reference interpreter and checks
`include "cpu_bus_defs.svh"

module tb_cpu_bus;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_tests   = 6;
  localparam int mem_words = 1 << `TB_MEM_AW;
  localparam int data_base = 32;  // data words of every test start here

  logic               clk;
  logic               reset;
  cpu_bus_pkg::byte_t ui_in  = 8'h01;
  cpu_bus_pkg::byte_t uio_in = 8'h00;
  cpu_bus_pkg::byte_t uo_out;
  cpu_bus_pkg::byte_t uio_out;
  cpu_bus_pkg::byte_t uio_oe;

  // test table with expected columns from the interpreter
  string              name_tbl   [n_tests];
  cpu_bus_pkg::word_t prog_tbl   [n_tests][8];
  cpu_bus_pkg::word_t data_tbl   [n_tests][4];
  logic               gap_tbl    [n_tests];
  cpu_bus_pkg::word_t exp_data   [n_tests][4];
  int                 exp_frames [n_tests];

  cpu_bus_pkg::word_t mem     [mem_words];  // off-chip memory
  cpu_bus_pkg::word_t ref_mem [mem_words];  // interpreter copy

  int     cur_test      = 0;
  logic   gap_mode      = 1'b0;
  integer seed          = 32'h3100b3c0;
  int     rnd;
  int     cycles        = 0;
  int     timeout_limit = 0;
  int     mon_errors    = 0;
  int     chk_errors    = 0;
  int     failed_tests  = 0;

  // bus model state
  int                 ph;          // expected DUT phase in the current cycle
  logic               boot;        // processor idles one cycle after reset
  logic               stop;        // HALT has been fetched
  logic               next_fetch;  // next frame is an instruction fetch
  int                 frame_count;
  cpu_bus_pkg::word_t fr_addr;
  cpu_bus_pkg::word_t fr_wdata;
  cpu_bus_pkg::word_t fetch_word;
  logic               fr_write;
  logic [3:0]         oe_on;
  logic [3:0]         oe_off;

  cpu_bus_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .ui_in   (ui_in),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic cpu_bus_pkg::word_t encode_instr(input cpu_bus_pkg::opcode_t op,
                                                      input logic [23:0] operand);
    encode_instr = {op, 4'h0, operand};
  endfunction

  // NOP carrying the address twice in its operand
  function automatic cpu_bus_pkg::word_t fill_word(input int idx);
    fill_word = 32'h00a5_0000 | (32'(idx) * 32'h0000_0101);
  endfunction

  task automatic build_table();
    int t;
    int k;
    for (t = 0; t < n_tests; t++) begin
      for (k = 0; k < 8; k++) prog_tbl[t][k] = encode_instr(`OP_HALT, 24'h0);
      for (k = 0; k < 4; k++) data_tbl[t][k] = '0;
      gap_tbl[t] = 1'b0;
    end
    name_tbl[0]    = "ldi_store";
    prog_tbl[0][0] = encode_instr(`OP_LDI, 24'hc3a581);
    prog_tbl[0][1] = encode_instr(`OP_ST, 24'd33);
    data_tbl[0][1] = 32'h5a5a_5a5a;

    name_tbl[1]    = "arith_wrap";
    prog_tbl[1][0] = encode_instr(`OP_LD, 24'd32);
    prog_tbl[1][1] = encode_instr(`OP_ADD, 24'd33);  // carries out of bit 31
    prog_tbl[1][2] = encode_instr(`OP_SUB, 24'd34);  // borrows
    prog_tbl[1][3] = encode_instr(`OP_ST, 24'd35);
    data_tbl[1][0] = 32'hffff_fff0;
    data_tbl[1][1] = 32'h0000_0025;
    data_tbl[1][2] = 32'h8000_0020;

    // count down from data word 0 and store the final acc to word 2
    name_tbl[2]    = "count_loop";
    prog_tbl[2][0] = encode_instr(`OP_LD, 24'd32);
    prog_tbl[2][1] = encode_instr(`OP_JZ, 24'd6);
    prog_tbl[2][2] = encode_instr(`OP_SUB, 24'd33);
    prog_tbl[2][3] = encode_instr(`OP_ST, 24'd32);
    prog_tbl[2][4] = encode_instr(`OP_JMP, 24'd1);
    prog_tbl[2][5] = encode_instr(`OP_NOP, 24'd0);
    prog_tbl[2][6] = encode_instr(`OP_ST, 24'd34);
    data_tbl[2][0] = 32'd3;
    data_tbl[2][1] = 32'd1;
    data_tbl[2][2] = 32'h0000_5555;

    name_tbl[3] = "count_loop_gaps";
    prog_tbl[3] = prog_tbl[2];
    data_tbl[3] = data_tbl[2];
    gap_tbl[3]  = 1'b1;

    name_tbl[4]    = "halt_idle";
    prog_tbl[4][0] = encode_instr(`OP_LDI, 24'd7);
    prog_tbl[4][1] = encode_instr(`OP_HALT, 24'd0);
    prog_tbl[4][2] = encode_instr(`OP_ST, 24'd32);   // never reached
    data_tbl[4][0] = 32'hdead_beef;

    name_tbl[5]    = "unknown_op";
    prog_tbl[5][0] = encode_instr(`OP_LDI, 24'h000042);
    prog_tbl[5][1] = encode_instr(4'd9, 24'd32);
    prog_tbl[5][2] = encode_instr(`OP_ADD, 24'd33);
    prog_tbl[5][3] = encode_instr(`OP_ST, 24'd34);
    prog_tbl[5][4] = encode_instr(4'hc, 24'd35);
    data_tbl[5][1] = 32'h0000_0100;
  endtask

  // instruction-level model giving final data words and frames up to HALT
  task automatic predict_results(input int t);
    cpu_bus_pkg::word_t pc;
    cpu_bus_pkg::word_t acc;
    cpu_bus_pkg::word_t ins;
    cpu_bus_pkg::word_t opnd;
    int                 frames;
    int                 steps;
    int                 i;
    logic               done;
    for (i = 0; i < mem_words; i++) ref_mem[i] = fill_word(i);
    for (i = 0; i < 8; i++) ref_mem[i] = prog_tbl[t][i];
    for (i = 0; i < 4; i++) ref_mem[data_base + i] = data_tbl[t][i];
    pc     = '0;
    acc    = '0;
    frames = 0;
    steps  = 0;
    done   = 1'b0;
    while (!done && steps < 1000) begin
      ins  = ref_mem[pc[`TB_MEM_AW-1:0]];
      opnd = {8'h00, ins[23:0]};
      frames++;
      steps++;
      pc = pc + 32'd1;
      case (ins[31:28])
        `OP_LDI: acc = opnd;
        `OP_LD: begin
          acc = ref_mem[opnd[`TB_MEM_AW-1:0]];
          frames++;
        end
        `OP_ST: begin
          ref_mem[opnd[`TB_MEM_AW-1:0]] = acc;
          frames++;
        end
        `OP_ADD: begin
          acc = acc + ref_mem[opnd[`TB_MEM_AW-1:0]];
          frames++;
        end
        `OP_SUB: begin
          acc = acc - ref_mem[opnd[`TB_MEM_AW-1:0]];
          frames++;
        end
        `OP_JZ: if (acc == '0) pc = opnd;
        `OP_JMP: pc = opnd;
        `OP_HALT: done = 1'b1;
        default: ;  // unlisted opcodes do nothing
      endcase
    end
    for (i = 0; i < 4; i++) exp_data[t][i] = ref_mem[data_base + i];
    exp_frames[t] = frames;
  endtask

  // run enable with random low cycles in gap tests
  always @(posedge clk) begin
    if (gap_mode) begin
      rnd = $random(seed);
      ui_in <= {7'b0, (rnd[1:0] != 2'b00)};
    end else begin
      ui_in <= 8'h01;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (timeout_limit > 0 && cycles >= timeout_limit) begin
      $display("timeout: the DUT did not reach HALT within %0d cycles", timeout_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // external memory decoding frames by cycle position
  always @(posedge clk) begin : bus_model
    int i;
    int idx;
    if (reset) begin
      for (i = 0; i < mem_words; i++) mem[i] = fill_word(i);
      for (i = 0; i < 8; i++) mem[i] = prog_tbl[cur_test][i];
      for (i = 0; i < 4; i++) mem[data_base + i] = data_tbl[cur_test][i];
      ph          = 0;
      boot        = 1'b1;
      stop        = 1'b0;
      next_fetch  = 1'b1;
      frame_count = 0;
      fetch_word  = '0;
      uio_in     <= 8'h00;
    end else begin
      if (ph >= `PH_ADDR_FIRST + 1 && ph <= `PH_ADDR_LAST + 1) begin
        i = ph - `PH_ADDR_FIRST - 1;  // byte number counted low first
        fr_addr[i*8 +: 8]  = uo_out;
        fr_wdata[i*8 +: 8] = uio_out;
        oe_on[i]  = (uio_oe == 8'hff);
        oe_off[i] = (uio_oe == 8'h00);
      end else begin
        assert (uio_oe == 8'h00 && uio_out == 8'h00) else begin
          mon_errors++;
          $display("error at %0t: uio_oe %h uio_out %h outside write bytes",
                   $time, uio_oe, uio_out);
        end
        if (ph == `PH_STATUS + 1) begin
          fr_write = uo_out[0];
          assert (uo_out[7:1] == 7'h00) else begin
            mon_errors++;
            $display("error at %0t: status byte %h", $time, uo_out);
          end
          assert (fr_write == (!next_fetch && fetch_word[31:28] == `OP_ST)) else begin
            mon_errors++;
            $display("error at %0t: write flag %b wrong for this frame", $time, fr_write);
          end
          assert (next_fetch || fr_addr == {8'h00, fetch_word[23:0]}) else begin
            mon_errors++;
            $display("error at %0t: data address %h, operand %h", $time, fr_addr,
                     fetch_word[23:0]);
          end
          assert (fr_addr < mem_words) else begin
            mon_errors++;
            $display("error at %0t: address %h outside memory", $time, fr_addr);
          end
          if (fr_write) begin
            assert (oe_on == 4'hf) else begin
              mon_errors++;
              $display("error at %0t: uio_oe not all ones on write bytes", $time);
            end
          end else begin
            assert (oe_off == 4'hf && fr_wdata == '0) else begin
              mon_errors++;
              $display("error at %0t: uio driven during a read frame", $time);
            end
          end
        end else begin
          // address pins parked in idle and read cycles
          assert ({uo_out[7:2], uo_out[0]} == 7'h00 && (stop || !uo_out[1])) else begin
            mon_errors++;
            $display("error at %0t: uo_out %h while idle or reading", $time, uo_out);
          end
        end
      end
      idx = int'(fr_addr[`TB_MEM_AW-1:0]);
      if (ph >= `PH_DATA_IN_FIRST - 1 && ph <= `FRAME_LEN - 2) begin
        uio_in <= mem[idx][(ph - `PH_DATA_IN_FIRST + 1)*8 +: 8];
      end else begin
        uio_in <= 8'h00;
      end
      if (ph == `FRAME_LEN - 1) begin
        frame_count++;
        if (fr_write) mem[idx] = fr_wdata;
        if (next_fetch) begin
          fetch_word = mem[idx];
          case (fetch_word[31:28])
            `OP_LD, `OP_ST, `OP_ADD, `OP_SUB: next_fetch = 1'b0;
            `OP_HALT: stop = 1'b1;
            default: ;
          endcase
        end else begin
          next_fetch = 1'b1;
        end
      end
      if (ph == 0) begin
        if (boot) boot = 1'b0;
        else if (!stop && ui_in[0]) ph = 1;  // request always up unless halting
      end else if (ph == `FRAME_LEN - 1) begin
        ph = 0;
      end else begin
        ph = ph + 1;
      end
    end
  end

  task automatic run_test(input int t);
    int start_err;
    int halt_frames;
    int n;
    int i;
    start_err = mon_errors + chk_errors;
    @(posedge clk);
    cur_test <= t;
    gap_mode <= gap_tbl[t];
    reset    <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    while (!(stop && uo_out[1])) @(negedge clk);
    halt_frames = frame_count;
    for (i = 0; i < 50; i++) begin
      @(negedge clk);
      assert (uo_out == 8'h02 && uio_oe == 8'h00) else begin
        chk_errors++;
        $display("error at %0t: after HALT uo_out %h uio_oe %h", $time, uo_out, uio_oe);
      end
    end
    assert (halt_frames == exp_frames[t]) else begin
      chk_errors++;
      $display("error at %0t: %0d frames up to HALT, expected %0d", $time, halt_frames,
               exp_frames[t]);
    end
    for (i = 0; i < 4; i++) begin
      assert (mem[data_base + i] == exp_data[t][i]) else begin
        chk_errors++;
        $display("error at %0t: data word %0d is %h, expected %h", $time, i,
                 mem[data_base + i], exp_data[t][i]);
      end
    end
    n = mon_errors + chk_errors - start_err;
    if (n != 0) failed_tests++;
    $display("test %0d %s: %s, %0d frames, %0d errors", t, name_tbl[t],
             (n == 0) ? "pass" : "FAIL", halt_frames, n);
  endtask

  initial begin
    int t;
    reset = 1'b1;
    build_table();
    timeout_limit = 200;
    for (t = 0; t < n_tests; t++) begin
      predict_results(t);
      timeout_limit += 3 * 11 * exp_frames[t];
    end
    for (t = 0; t < n_tests; t++) run_test(t);
    $display("summary: %0d tests, %0d failed, %0d errors", n_tests, failed_tests,
             mon_errors + chk_errors);
    if (mon_errors + chk_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
cpu_bus_pkg.sv
bus_serializer.sv
accum_cpu.sv
cpu_bus_top.sv
tb_cpu_bus.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_cpu_bus
RTL_TOP    ?= cpu_bus_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= -Wall -Wno-fatal

RTL_SRCS = cpu_bus_pkg.sv bus_serializer.sv accum_cpu.sv cpu_bus_top.sv
SRCS     = $(RTL_SRCS) tb_cpu_bus.sv cpu_bus_defs.svh
SIM_BIN  = $(BUILD_DIR)/V$(TOP)
PASS_MSG = Done: no errors
FAIL_MSG = Done: errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) +incdir+. $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; \
	else echo "simulation passed"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
